// ==== soc_consts.svh ====
// Widths, address map, INFO selectors and ACTION codes of the SoC control block.
// Included by the package, the RTL modules and the testbench.
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

`define WORD_W         32
`define ADDR_W         12
`define DEV_CNT        4
`define DEV_IDX_W      2
`define MAP_WINDOW     1024             // Mapping window in words.
`define DEVTBL_MAPSZ   16               // Entry 0 map size.
`define RAM_BASE       16
`define RAM_WORDS      64
`define RAM_IDX_W      6
`define RAM_ID         1                // Id of a RAM-class device.

`define INFO_VERSION   0
`define INFO_CACHESZ   1
`define INFO_RSTSTATE  2
`define INFO_PRELOADER 3
`define INFO_SOCID     4

`define SOC_VERSION    32'h0001_0003
`define CACHE_SZ       32'd2
`define PRELDR_ADDR    32'h0000_0400
`define SOC_ID         32'h0000_5a01

`define ACT_PWROFF     0
`define ACT_WRESET     1
`define ACT_CRESET     2
`define ACT_RRESET     3

`endif

// ==== soc_pkg.sv ====
// Bus types shared by the RTL modules and the testbench.
// Import with a wildcard in the module header.
`include "soc_consts.svh"

package soc_pkg;

	// Peripheral bus operation. OP_RW is a swap.
	typedef enum logic [1:0] {
		OP_NOP = 2'b00,
		OP_WR  = 2'b01,
		OP_RD  = 2'b10,
		OP_RW  = 2'b11
	} bus_op_t;

	typedef logic [`WORD_W-1:0] word_t;  // Data word.
	typedef logic [`ADDR_W-1:0] addr_t;  // Word address.
	typedef logic [`ADDR_W-1:0] mapsz_t; // Map size in words.

endpackage

// ==== bus_switch.sv ====
// Arbiter and decoder between two four-phase bus masters and the slaves.
// Grants one master at a time round-robin, selects the slave for one
// cycle and returns the read word with ack until the master drops req.
`timescale 1ns/1ps
`include "soc_consts.svh"

module bus_switch import soc_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_i,

	input  logic    m_req_i   [2],
	input  bus_op_t m_op_i    [2],
	input  addr_t   m_addr_i  [2],
	input  word_t   m_wdata_i [2],
	output logic    m_ack_o   [2],
	output word_t   m_rdata_o [2],

	output bus_op_t s_op_o,
	output addr_t   s_addr_o,
	output word_t   s_wdata_o,
	output logic    devtbl_sel_o,
	output logic    ram_sel_o,
	input  word_t   devtbl_rdata_i,
	input  word_t   ram_rdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_CAPTURE,
		ST_ACKWAIT
	} state_t;

	state_t state;
	logic   grant;      // Master being served.
	logic   last;       // Master served most recently.
	logic   pick;       // Winner among pending requests.
	logic   hit_devtbl;
	logic   hit_ram;
	word_t  cap_data;

	// Round-robin choice. The master not served last wins a tie.
	always_comb begin
		if (m_req_i[0] && m_req_i[1]) begin
			pick = ~last;
		end else begin
			pick = m_req_i[1];
		end
	end

	// Decode of the latched address.
	assign hit_devtbl = (s_addr_o < addr_t'(`RAM_BASE));
	assign hit_ram = (s_addr_o >= addr_t'(`RAM_BASE)) &&
		(s_addr_o < addr_t'(`RAM_BASE + `RAM_WORDS));

	assign devtbl_sel_o = (state == ST_ACCESS) && hit_devtbl; // One cycle only.
	assign ram_sel_o = (state == ST_ACCESS) && hit_ram;

	// Unmapped addresses read as zero.
	always_comb begin
		if (hit_devtbl) begin
			cap_data = devtbl_rdata_i;
		end else if (hit_ram) begin
			cap_data = ram_rdata_i;
		end else begin
			cap_data = '0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state      <= ST_IDLE;
			grant      <= 1'b0;
			last       <= 1'b1; // Master 0 first after reset.
			m_ack_o[0] <= 1'b0;
			m_ack_o[1] <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (m_req_i[0] || m_req_i[1]) begin
						grant <= pick;
						state <= ST_ACCESS;
					end
				end
				ST_ACCESS: begin
					state <= ST_CAPTURE; // Slave registers its word.
				end
				ST_CAPTURE: begin
					m_ack_o[grant] <= 1'b1;
					last           <= grant;
					state          <= ST_ACKWAIT;
				end
				ST_ACKWAIT: begin
					// Stall here while the master holds req.
					if (!m_req_i[grant]) begin
						m_ack_o[grant] <= 1'b0;
						state          <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Request payload follows the pending winner while idle.
	always_ff @(posedge clk_i) begin
		if (state == ST_IDLE) begin
			s_op_o    <= m_op_i[pick];
			s_addr_o  <= m_addr_i[pick];
			s_wdata_o <= m_wdata_i[pick];
		end
		if (state == ST_CAPTURE) begin
			m_rdata_o[grant] <= cap_data; // Held while ack is high.
		end
	end

endmodule

// ==== dev_table.sv ====
// Device table slave on the peripheral bus.
// Serves descriptor reads, INFO queries and reset ACTION commands, and
// sizes the first RAM mapping from the configured descriptor entries.
`timescale 1ns/1ps
`include "soc_consts.svh"

module dev_table import soc_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_i,

	input  logic                sel_i,
	input  bus_op_t             op_i,
	input  addr_t               addr_i,
	input  word_t               wdata_i,
	output word_t               rdata_o,

	input  word_t               dev_id_i    [`DEV_CNT],
	input  mapsz_t              dev_mapsz_i [`DEV_CNT],
	input  logic [`DEV_CNT-1:0] dev_useintr_i,

	output logic                pwr_off_o,
	output logic                warm_reset_o,
	output logic                reload_o
);

	mapsz_t                first_ram_mapsz; // Reported as entry 1.
	mapsz_t                ram_mapsz_next;
	logic                  ram_found;
	logic                  reloaded;        // Set by RRESET.
	addr_t                 entry;
	logic [`DEV_IDX_W-1:0] entry_idx;
	mapsz_t                ent_mapsz;
	word_t                 desc_word;
	word_t                 info_word;
	logic                  is_action;

	// Walk past entries 0 and 1 until the first RAM-class device.
	always_comb begin
		ram_mapsz_next = mapsz_t'(`MAP_WINDOW - `DEVTBL_MAPSZ);
		ram_found      = 1'b0;
		for (int i = 2; i < `DEV_CNT; i++) begin
			if (dev_id_i[i] == `RAM_ID) begin
				ram_found = 1'b1;
			end
			if (!ram_found) begin
				ram_mapsz_next = ram_mapsz_next - dev_mapsz_i[i];
			end
		end
	end

	// Each entry takes an id word followed by a map size word.
	assign entry     = addr_i >> 1;
	assign entry_idx = entry[`DEV_IDX_W-1:0];

	always_comb begin
		if (entry_idx == 0) begin
			ent_mapsz = mapsz_t'(`DEVTBL_MAPSZ);
		end else if (entry_idx == 1) begin
			ent_mapsz = first_ram_mapsz;
		end else begin
			ent_mapsz = dev_mapsz_i[entry_idx];
		end
	end

	always_comb begin
		if (entry >= addr_t'(`DEV_CNT)) begin
			desc_word = '0; // Past the last entry.
		end else if (addr_i[0]) begin
			desc_word = word_t'({ent_mapsz, dev_useintr_i[entry_idx]});
		end else begin
			desc_word = dev_id_i[entry_idx];
		end
	end

	// INFO word by selector in wdata.
	always_comb begin
		case (wdata_i)
			`INFO_VERSION:   info_word = `SOC_VERSION;
			`INFO_CACHESZ:   info_word = `CACHE_SZ;
			`INFO_RSTSTATE:  info_word = word_t'({warm_reset_o, pwr_off_o});
			`INFO_PRELOADER: info_word = reloaded ? '0 : `PRELDR_ADDR;
			`INFO_SOCID:     info_word = `SOC_ID;
			default:         info_word = '0;
		endcase
	end

	assign is_action = sel_i && (op_i == OP_RW) && (addr_i == addr_t'(1));

	// Reset levels and the reload pulse.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pwr_off_o    <= 1'b0;
			warm_reset_o <= 1'b0;
			reload_o     <= 1'b0;
			reloaded     <= 1'b0;
		end else begin
			reload_o <= is_action && (wdata_i == `ACT_RRESET); // Single cycle.
			if (is_action) begin
				case (wdata_i)
					`ACT_PWROFF: begin
						pwr_off_o    <= 1'b1;
						warm_reset_o <= 1'b0;
					end
					`ACT_WRESET: begin
						pwr_off_o    <= 1'b0;
						warm_reset_o <= 1'b1;
					end
					`ACT_CRESET: begin
						pwr_off_o    <= 1'b1;
						warm_reset_o <= 1'b1;
					end
					`ACT_RRESET: begin
						reloaded <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		first_ram_mapsz <= ram_mapsz_next;
		if (sel_i) begin
			case (op_i)
				OP_RD: rdata_o <= desc_word;
				OP_RW: rdata_o <= (addr_i == '0) ? info_word : '0; // ACTION returns zero.
				default: rdata_o <= '0;
			endcase
		end
	end

endmodule

// ==== scratch_ram.sv ====
// Word-addressed scratch RAM slave on the peripheral bus.
// Read, write and swap with one cycle from select to read word.
`timescale 1ns/1ps
`include "soc_consts.svh"

module scratch_ram import soc_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_i,

	input  logic    sel_i,
	input  bus_op_t op_i,
	input  addr_t   addr_i,
	input  word_t   wdata_i,
	output word_t   rdata_o
);

	word_t                 mem [`RAM_WORDS];
	logic [`RAM_IDX_W-1:0] idx;

	// Offset from the start of the RAM region.
	assign idx = `RAM_IDX_W'(addr_i - addr_t'(`RAM_BASE));

	always_ff @(posedge clk_i) begin
		if (sel_i && (op_i == OP_WR || op_i == OP_RW)) begin
			mem[idx] <= wdata_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rdata_o <= '0;
		end else if (sel_i) begin
			case (op_i)
				OP_RD: rdata_o <= mem[idx];
				OP_RW: rdata_o <= mem[idx]; // Old word of the swap.
				default: rdata_o <= '0;
			endcase
		end
	end

endmodule

// ==== soc_top.sv ====
// Top level of the SoC control block.
// Two master ports share the bus to the device table and the scratch RAM;
// the descriptor table comes in on the configuration ports.
`timescale 1ns/1ps
`include "soc_consts.svh"

module soc_top import soc_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_i,

	input  logic                m_req_i   [2],
	input  bus_op_t             m_op_i    [2],
	input  addr_t               m_addr_i  [2],
	input  word_t               m_wdata_i [2],
	output logic                m_ack_o   [2],
	output word_t               m_rdata_o [2],

	input  word_t               dev_id_i    [`DEV_CNT],
	input  mapsz_t              dev_mapsz_i [`DEV_CNT],
	input  logic [`DEV_CNT-1:0] dev_useintr_i,

	output logic                pwr_off_o,
	output logic                warm_reset_o,
	output logic                reload_o
);

	bus_op_t s_op;
	addr_t   s_addr;
	word_t   s_wdata;
	logic    devtbl_sel;
	logic    ram_sel;
	word_t   devtbl_rdata;
	word_t   ram_rdata;

	bus_switch u_switch (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.m_req_i        (m_req_i),
		.m_op_i         (m_op_i),
		.m_addr_i       (m_addr_i),
		.m_wdata_i      (m_wdata_i),
		.m_ack_o        (m_ack_o),
		.m_rdata_o      (m_rdata_o),
		.s_op_o         (s_op),
		.s_addr_o       (s_addr),
		.s_wdata_o      (s_wdata),
		.devtbl_sel_o   (devtbl_sel),
		.ram_sel_o      (ram_sel),
		.devtbl_rdata_i (devtbl_rdata),
		.ram_rdata_i    (ram_rdata)
	);

	dev_table u_devtbl (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.sel_i         (devtbl_sel),
		.op_i          (s_op),
		.addr_i        (s_addr),
		.wdata_i       (s_wdata),
		.rdata_o       (devtbl_rdata),
		.dev_id_i      (dev_id_i),
		.dev_mapsz_i   (dev_mapsz_i),
		.dev_useintr_i (dev_useintr_i),
		.pwr_off_o     (pwr_off_o),
		.warm_reset_o  (warm_reset_o),
		.reload_o      (reload_o)
	);

	scratch_ram u_ram (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.sel_i   (ram_sel),
		.op_i    (s_op),
		.addr_i  (s_addr),
		.wdata_i (s_wdata),
		.rdata_o (ram_rdata)
	);

endmodule

// ==== tb_soc.sv ====
// Testbench for the SoC control block. Drives both bus masters through
// descriptor reads, INFO queries, ACTION commands and RAM traffic, and
// checks every response against a model kept here.
`timescale 1ns/1ps
`include "soc_consts.svh"

module tb_soc import soc_pkg::*; ();

	localparam int N_CFG = 6;
	localparam int N_ACT = 12;
	localparam int N_RAM = 40; // Per master.
	localparam int N_CON = 30;
	localparam int N_TXN = `RAM_WORDS + N_CFG * `RAM_BASE + 7 + 3 * N_ACT +
		2 * N_RAM + 2 * N_CON;
	localparam int LIMIT = 20 * N_TXN + 100;

	logic                clk = 1'b0;
	logic                rst;
	logic                m_req     [2];
	bus_op_t             m_op      [2];
	addr_t               m_addr    [2];
	word_t               m_wdata   [2];
	logic                m_ack     [2];
	word_t               m_rdata   [2];
	word_t               dev_id    [`DEV_CNT];
	mapsz_t              dev_mapsz [`DEV_CNT];
	logic [`DEV_CNT-1:0] dev_useintr;
	logic                pwr_off;
	logic                warm_reset;
	logic                reload;

	word_t       ram_model [`RAM_WORDS];
	logic        exp_pwr;
	logic        exp_warm;
	logic        exp_reloaded;
	int          exp_reloads;
	int          reload_seen = 0;
	int          cycles = 0;
	int          done_cnt  [2];
	logic [31:0] rand_st   [2];
	int          checks;
	int          word_errs;
	int          level_errs;
	int          count_errs;
	int          other_errs;

	soc_top i_dut (
		.clk_i         (clk),
		.rst_i         (rst),
		.m_req_i       (m_req),
		.m_op_i        (m_op),
		.m_addr_i      (m_addr),
		.m_wdata_i     (m_wdata),
		.m_ack_o       (m_ack),
		.m_rdata_o     (m_rdata),
		.dev_id_i      (dev_id),
		.dev_mapsz_i   (dev_mapsz),
		.dev_useintr_i (dev_useintr),
		.pwr_off_o     (pwr_off),
		.warm_reset_o  (warm_reset),
		.reload_o      (reload)
	);

	always #4 clk = ~clk; // 8 ns period.

	// The reload pulse is stable around the falling edge.
	always @(negedge clk) begin
		if (!rst && reload === 1'b1) begin
			reload_seen++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout, the run did not finish within %0d cycles", LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand(input int s);
		logic [31:0] x;
		x = rand_st[s];
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rand_st[s] = x;
		return x;
	endfunction

	function automatic bus_op_t rand_op(input logic [1:0] r);
		case (r)
			2'd1:    return OP_WR;
			2'd2:    return OP_RW;
			default: return OP_RD;
		endcase
	endfunction

	// One address in four lies outside the map.
	function automatic addr_t rand_addr(input logic [31:0] r);
		if (r[31:30] == 2'b00) begin
			return addr_t'(`RAM_BASE + `RAM_WORDS +
				r[29:0] % ((1 << `ADDR_W) - `RAM_BASE - `RAM_WORDS));
		end
		return addr_t'(`RAM_BASE + r[15:0] % `RAM_WORDS);
	endfunction

	// Window left over once the devices ahead of the first RAM are mapped.
	function automatic mapsz_t first_ram_size();
		int sz;
		sz = `MAP_WINDOW - `DEVTBL_MAPSZ;
		for (int i = 2; i < `DEV_CNT; i++) begin
			if (dev_id[i] == `RAM_ID) begin
				break;
			end
			sz = sz - int'(dev_mapsz[i]);
		end
		return mapsz_t'(sz);
	endfunction

	function automatic word_t desc_expect(input int a);
		int     e;
		mapsz_t sz;
		e = a / 2;
		if (e >= `DEV_CNT) begin
			return '0;
		end
		if (a % 2 == 0) begin
			return dev_id[e];
		end
		sz = (e == 0) ? mapsz_t'(`DEVTBL_MAPSZ) : (e == 1) ? first_ram_size() : dev_mapsz[e];
		return (word_t'(sz) << 1) | word_t'(dev_useintr[e]);
	endfunction

	function automatic word_t info_expect(input int s);
		case (s)
			`INFO_VERSION:   return `SOC_VERSION;
			`INFO_CACHESZ:   return `CACHE_SZ;
			`INFO_RSTSTATE:  return word_t'({exp_warm, exp_pwr});
			`INFO_PRELOADER: return exp_reloaded ? '0 : `PRELDR_ADDR;
			`INFO_SOCID:     return `SOC_ID;
			default:         return '0;
		endcase
	endfunction

	// Expected word of a RAM access. The model takes any write.
	function automatic word_t ram_expect(input bus_op_t op, input addr_t addr, input word_t wdata);
		int    idx;
		word_t old;
		if (addr < addr_t'(`RAM_BASE) || addr >= addr_t'(`RAM_BASE + `RAM_WORDS)) begin
			return '0;
		end
		idx = int'(addr) - `RAM_BASE;
		old = ram_model[idx];
		if (op == OP_WR || op == OP_RW) begin
			ram_model[idx] = wdata;
		end
		return (op == OP_RD || op == OP_RW) ? old : '0;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			word_errs++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Levels are {pwr_off, warm_reset, reload}.
	task automatic check_levels(input string name, input logic [2:0] exp, input logic [2:0] act);
		checks++;
		if (act !== exp) begin
			level_errs++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			count_errs++;
			$display("error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Raise req and wait for ack. Called 1 ns after a rising edge.
	task automatic bus_start(input int m, input bus_op_t op, input addr_t addr,
		input word_t wdata, output word_t rdata);
		int base;
		base = done_cnt[1 - m];
		m_op[m] = op;
		m_addr[m] = addr;
		m_wdata[m] = wdata;
		m_req[m] = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!m_ack[m]);
		rdata = m_rdata[m];
		if (done_cnt[1 - m] - base > 1) begin
			other_errs++;
			$display("master %0d waited for %0d transactions of the other master",
				m, done_cnt[1 - m] - base);
		end
		done_cnt[m]++;
	endtask

	// Hold req for a few cycles, then close the handshake.
	task automatic bus_end(input int m, input int hold);
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		m_req[m] = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (m_ack[m]);
	endtask

	task automatic bus_xfer(input int m, input bus_op_t op, input addr_t addr,
		input word_t wdata, output word_t rdata);
		bus_start(m, op, addr, wdata, rdata);
		bus_end(m, 0);
	endtask

	// The model is updated at ack in the order the bus served them.
	task automatic ram_txn(input string name, input int m, input bus_op_t op,
		input addr_t addr, input word_t wdata, input int hold);
		word_t rd;
		bus_start(m, op, addr, wdata, rd);
		check_word(name, ram_expect(op, addr, wdata), rd);
		bus_end(m, hold);
	endtask

	task automatic ram_traffic(input int m, input int n);
		logic [31:0] r;
		for (int k = 0; k < n; k++) begin
			r = next_rand(m);
			repeat (int'(r[9:8])) begin
				@(posedge clk);
				#1;
			end
			ram_txn($sformatf("ram_m%0d", m), m, rand_op(r[1:0]),
				addr_t'(`RAM_BASE + r[31:16] % `RAM_WORDS), next_rand(m), int'(r[5:4]) % 3);
		end
	endtask

	// Config 0 has no RAM entry. Configs 1 and 2 stop at entries 2 and 3.
	task automatic make_config(input int c);
		logic [31:0] r;
		logic        ram_here;
		r = next_rand(0);
		dev_id[0] = r | 32'h2;
		dev_id[1] = `RAM_ID;
		dev_mapsz[0] = mapsz_t'(r[11:0]); // Ignored by the table.
		dev_mapsz[1] = mapsz_t'(r[23:12]);
		dev_useintr = r[27:24];
		for (int i = 2; i < `DEV_CNT; i++) begin
			r = next_rand(0);
			ram_here = (c == 1 && i == 2) || (c == 2 && i == 3) || (c > 2 && r % 3 == 0);
			dev_id[i] = ram_here ? `RAM_ID : (r | 32'h2);
			dev_mapsz[i] = mapsz_t'(r[15:8]);
		end
	endtask

	initial begin
		word_t       rd;
		logic [31:0] r;
		int          code;
		int          off;

		rand_st[0] = 32'hc1842158;
		rand_st[1] = 32'hc1842158 ^ 32'h5bd1e995;
		for (int m = 0; m < 2; m++) begin
			m_req[m] = 1'b0;
			m_op[m] = OP_NOP;
			m_addr[m] = '0;
			m_wdata[m] = '0;
			done_cnt[m] = 0;
		end
		for (int i = 0; i < `DEV_CNT; i++) begin
			dev_id[i] = '0;
			dev_mapsz[i] = '0;
		end
		dev_useintr = '0;
		exp_pwr = 1'b0;
		exp_warm = 1'b0;
		exp_reloaded = 1'b0;
		exp_reloads = 0;
		checks = 0;
		word_errs = 0;
		level_errs = 0;
		count_errs = 0;
		other_errs = 0;

		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
		check_levels("reset", 3'b000, {pwr_off, warm_reset, reload});
		if (m_ack[0] !== 1'b0 || m_ack[1] !== 1'b0) begin
			other_errs++;
			$display("an ack is not low after reset");
		end

		for (int a = 0; a < `RAM_WORDS; a++) begin
			ram_txn("ram_fill", 0, OP_WR, addr_t'(`RAM_BASE + a), next_rand(0), 0);
		end

		for (int c = 0; c < N_CFG; c++) begin
			make_config(c);
			@(posedge clk);
			#1;
			for (int a = 0; a < `RAM_BASE; a++) begin
				bus_xfer(c % 2, OP_RD, addr_t'(a), next_rand(0), rd);
				check_word($sformatf("desc_cfg%0d_addr%0d", c, a), desc_expect(a), rd);
			end
		end

		for (int s = 0; s < 7; s++) begin
			bus_xfer(s % 2, OP_RW, addr_t'(0), word_t'(s), rd);
			check_word($sformatf("info_sel%0d", s), info_expect(s), rd);
		end

		// First four actions cover every code.
		off = int'(next_rand(0) % 4);
		for (int k = 0; k < N_ACT; k++) begin
			r = next_rand(0);
			code = (k < 4) ? (off + k) % 4 : int'(r % 4);
			bus_xfer(k % 2, OP_RW, addr_t'(1), word_t'(code), rd);
			check_word($sformatf("action%0d", k), '0, rd);
			case (code)
				`ACT_PWROFF: begin
					exp_pwr = 1'b1;
					exp_warm = 1'b0;
				end
				`ACT_WRESET: begin
					exp_pwr = 1'b0;
					exp_warm = 1'b1;
				end
				`ACT_CRESET: begin
					exp_pwr = 1'b1;
					exp_warm = 1'b1;
				end
				default: begin
					exp_reloaded = 1'b1;
					exp_reloads++;
				end
			endcase
			check_levels($sformatf("levels%0d", k), {exp_pwr, exp_warm, 1'b0},
				{pwr_off, warm_reset, reload});
			check_count($sformatf("reload_pulses%0d", k), exp_reloads, reload_seen);
			bus_xfer(k % 2, OP_RW, addr_t'(0), word_t'(`INFO_RSTSTATE), rd);
			check_word($sformatf("rststate%0d", k), info_expect(`INFO_RSTSTATE), rd);
			bus_xfer(k % 2, OP_RW, addr_t'(0), word_t'(`INFO_PRELOADER), rd);
			check_word($sformatf("preloader%0d", k), info_expect(`INFO_PRELOADER), rd);
		end

		fork
			ram_traffic(0, N_RAM);
			ram_traffic(1, N_RAM);
		join

		// Both masters raise req on the same edge.
		for (int k = 0; k < N_CON; k++) begin
			r = next_rand(0);
			fork
				ram_txn("contention_m0", 0, rand_op(r[1:0]), rand_addr(next_rand(0)),
					next_rand(0), int'(r[5:4]) % 3);
				ram_txn("contention_m1", 1, rand_op(r[3:2]), rand_addr(next_rand(1)),
					next_rand(1), int'(r[7:6]) % 3);
			join
		end

		repeat (2) @(posedge clk);
		$display("checks %0d, word errors %0d, level errors %0d, count errors %0d, other errors %0d",
			checks, word_errs, level_errs, count_errs, other_errs);
		if (word_errs + level_errs + count_errs + other_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+.
soc_pkg.sv
bus_switch.sv
dev_table.sv
scratch_ram.sv
soc_top.sv
tb_soc.sv

// ==== run.sh ====
#!/bin/sh
# Compiles the SoC testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_soc -f tb.f -o tb_soc_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
	echo "simulation passed"
	exit 0
fi

echo "pass message not found in $LOG"
exit 1
